//--- src.f
+incdir+hdl
hdl/ir_decd_pkg.sv
hdl/ir_decd_int.sv
hdl/ir_decd_vfpu.sv
hdl/ir_decd_issue_reg.sv
hdl/ir_decd_top.sv
sim/ir_decd_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the decoder testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module ir_decd_tb -f src.f -o ir_decd_sim

result=$(./obj_dir/ir_decd_sim)
echo "$result"

if echo "$result" | grep -q "SIMULATION PASSED"; then
  exit 0
fi
exit 1

//--- sim/ir_decd_tb.sv
// self-checking testbench; random legal insts only check out_valid, flags need a directed entry
`timescale 1ns/10ps
`include "ir_decd_config.svh"

module ir_decd_tb;

  // flag bits, msb first in the same order as act_flags
  localparam logic [14:0] fl_load    = 15'h4000;
  localparam logic [14:0] fl_store   = 15'h2000;
  localparam logic [14:0] fl_sync    = 15'h1000;
  localparam logic [14:0] fl_bar     = 15'h0800;
  localparam logic [14:0] fl_rts     = 15'h0400;
  localparam logic [14:0] fl_pcall   = 15'h0200;
  localparam logic [14:0] fl_pcfifo  = 15'h0100;
  localparam logic [14:0] fl_csr     = 15'h0080;
  localparam logic [14:0] fl_ecall   = 15'h0040;
  localparam logic [14:0] fl_vec     = 15'h0020;
  localparam logic [14:0] fl_fp      = 15'h0010;
  localparam logic [14:0] fl_vdiv    = 15'h0008;
  localparam logic [14:0] fl_vmul    = 15'h0004;
  localparam logic [14:0] fl_vsetvli = 15'h0002;
  localparam logic [14:0] fl_vsetvl  = 15'h0001;
  localparam int          max_wait   = 16;      // cycles before a wait gives up

  logic                   clk;
  logic                   arst_n;
  logic                   in_valid;
  logic                   illegal;
  logic                   amo_staddr;
  ir_decd_pkg::opcode_t   opcode;
  logic                   out_valid;
  logic                   load;
  logic                   store;
  logic                   sync;
  logic                   bar;
  logic                   rts;
  logic                   pcall;
  logic                   pcfifo;
  logic                   csr;
  logic                   ecall;
  logic                   vec;
  logic                   fp;
  logic                   vdiv;
  logic                   vmul;
  logic                   vsetvli;
  logic                   vsetvl;
  ir_decd_pkg::bar_type_t bar_type;
  logic [14:0]            act_flags;

  logic [14:0]            pend_flags;           // expectation riding with the inputs
  ir_decd_pkg::bar_type_t pend_bar;
  logic                   pend_chk;
  int                     pend_idx;
  logic                   exp_valid;            // expectation for the registered outputs
  logic [14:0]            exp_flags;
  ir_decd_pkg::bar_type_t exp_bar;
  logic                   exp_chk;
  int                     exp_idx;

  int                     err_count;
  int                     pass_count;
  int                     fail_count;
  logic [31:0]            rnd;

  string flag_names [15] = '{"load", "store", "sync", "bar", "rts", "pcall", "pcfifo", "csr",
                             "ecall", "vec", "fp", "vdiv", "vmul", "vsetvli", "vsetvl"};

  // directed instruction table
  string                  tbl_name  [$];
  ir_decd_pkg::opcode_t   tbl_op    [$];
  logic                   tbl_amo   [$];
  logic [14:0]            tbl_flags [$];
  ir_decd_pkg::bar_type_t tbl_bar   [$];
  int                     tbl_grp   [$];

  ir_decd_top uut (.*);

  assign act_flags = {load, store, sync, bar, rts, pcall, pcfifo, csr, ecall,
                      vec, fp, vdiv, vmul, vsetvli, vsetvl};

  always #4 clk = ~clk;                         // 8 ns period

  // ========================================
  // reference stage model and checks
  // ========================================
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      exp_valid <= 1'b0;
      exp_flags <= '0;
      exp_bar   <= '0;
      exp_chk   <= 1'b1;
      exp_idx   <= -1;
    end else begin
      exp_valid <= in_valid;
      exp_flags <= (in_valid && !illegal) ? pend_flags : '0;
      exp_bar   <= (in_valid && !illegal) ? pend_bar : '0;
      exp_chk   <= !in_valid || illegal || pend_chk;  // idle and illegal slots are all zero
      exp_idx   <= in_valid ? pend_idx : -1;
    end
  end

  valid_match: assert property (@(posedge clk) out_valid == exp_valid)
    else report_value("out_valid", {3'b000, $sampled(exp_valid)},
                      {3'b000, $sampled(out_valid)}, $sampled(exp_idx));

  flags_match: assert property (@(posedge clk) !exp_chk || (act_flags == exp_flags))
    else report_flags($sampled(exp_flags), $sampled(act_flags), $sampled(exp_idx));

  bar_match: assert property (@(posedge clk) !exp_chk || (bar_type == exp_bar))
    else report_value("bar_type", $sampled(exp_bar), $sampled(bar_type), $sampled(exp_idx));

  function automatic string inst_label(input int idx);
    if (idx >= 0) begin
      return tbl_name[idx];
    end
    return (idx == -2) ? "random" : "idle";
  endfunction

  function automatic void report_value(input string sig, input logic [3:0] expv,
                                       input logic [3:0] actv, input int idx);
    err_count++;
    $display("error: %s expected %h got %h (%s)", sig, expv, actv, inst_label(idx));
  endfunction

  function automatic void report_flags(input logic [14:0] expv, input logic [14:0] actv,
                                       input int idx);
    int i;
    for (i = 0; i < 15; i++) begin
      if (expv[14-i] !== actv[14-i]) begin
        report_value(flag_names[i], {3'b000, expv[14-i]}, {3'b000, actv[14-i]}, idx);
      end
    end
  endfunction

  // ========================================
  // stimulus helpers
  // ========================================
  function automatic void add_entry(input int grp, input string name,
                                    input ir_decd_pkg::opcode_t op, input logic amo,
                                    input logic [14:0] flags,
                                    input ir_decd_pkg::bar_type_t bt);
    tbl_grp.push_back(grp);
    tbl_name.push_back(name);
    tbl_op.push_back(op);
    tbl_amo.push_back(amo);
    tbl_flags.push_back(flags);
    tbl_bar.push_back(bt);
  endfunction

  function automatic void build_table();
    add_entry(2, "lw", 32'h0001_2283, 1'b0, fl_load, '0);
    add_entry(2, "ld", 32'h0081_3283, 1'b0, fl_load, '0);
    add_entry(2, "flw", 32'h0041_2087, 1'b0, fl_load, '0);
    add_entry(2, "c.lw", 32'h0000_4080, 1'b0, fl_load, '0);
    add_entry(2, "sw", 32'h0051_2023, 1'b0, fl_store, '0);
    add_entry(2, "fsd", 32'h0011_3427, 1'b0, fl_store, '0);
    add_entry(2, "c.sdsp", 32'h0000_e006, 1'b0, fl_store, '0);
    add_entry(2, "lr.w", 32'h1005_232f, 1'b0, fl_load | fl_sync, '0);
    add_entry(2, "sc.d", 32'h1865_32af, 1'b0, fl_store | fl_sync, '0);
    add_entry(2, "amoadd.w ld", 32'h0065_22af, 1'b0, fl_load | fl_sync, '0);
    add_entry(2, "amoadd.w st", 32'h0065_22af, 1'b1, fl_store | fl_sync, '0);
    add_entry(2, "fence rw,rw", 32'h0330_000f, 1'b0, fl_bar | fl_sync, `IR_BAR_RW_RW);
    add_entry(2, "fence iorw", 32'h0ff0_000f, 1'b0, fl_bar | fl_sync, `IR_BAR_FULL);
    add_entry(3, "jal x1", 32'h0000_00ef, 1'b0, fl_pcall | fl_pcfifo, '0);
    add_entry(3, "jalr x0,x1", 32'h0000_8067, 1'b0, fl_rts | fl_pcfifo, '0);
    add_entry(3, "jalr x1,x1", 32'h0000_80e7, 1'b0, fl_pcall | fl_pcfifo, '0); // push only
    add_entry(3, "c.jr x1", 32'h0000_8082, 1'b0, fl_rts | fl_pcfifo, '0);
    add_entry(3, "beq", 32'h0020_8063, 1'b0, fl_pcfifo, '0);
    add_entry(3, "auipc", 32'h0000_0297, 1'b0, fl_pcfifo, '0);
    add_entry(3, "csrrw", 32'h3003_12f3, 1'b0, fl_csr, '0);
    add_entry(3, "ecall", 32'h0000_0073, 1'b0, fl_ecall, '0);
    add_entry(4, "vadd.vv", 32'h0221_80d7, 1'b0, fl_vec, '0);
    add_entry(4, "vdiv.vv", 32'h8621_a0d7, 1'b0, fl_vec | fl_vdiv, '0);
    add_entry(4, "vmacc.vx", 32'hb622_e0d7, 1'b0, fl_vec | fl_vmul, '0);
    add_entry(4, "fdiv.s", 32'h1831_00d3, 1'b0, fl_fp | fl_vdiv, '0);
    add_entry(4, "vsetvli", 32'h0103_72d7, 1'b0, fl_vec | fl_vsetvli, '0);
    add_entry(4, "vsetvl", 32'h8073_72d7, 1'b0, fl_vec | fl_vsetvl, '0);
  endfunction

  task automatic send_inst(input ir_decd_pkg::opcode_t op, input logic amo, input logic ill,
                           input logic vld, input logic [14:0] flags,
                           input ir_decd_pkg::bar_type_t bt, input logic chk, input int idx);
    @(posedge clk);
    opcode     <= op;
    amo_staddr <= amo;
    illegal    <= ill;
    in_valid   <= vld;
    pend_flags <= flags;
    pend_bar   <= bt;
    pend_chk   <= chk;
    pend_idx   <= idx;
  endtask

  task automatic wait_out_valid(input int idx);
    int   n;
    logic seen;
    seen = 1'b0;
    for (n = 0; n < max_wait && !seen; n++) begin
      @(negedge clk);
      seen = out_valid;
    end
    if (!seen) begin
      err_count++;
      $display("timeout: out_valid never rose within %0d cycles for %s", max_wait,
               inst_label(idx));
    end
  endtask

  task automatic wait_idle();
    int   n;
    logic seen;
    seen = 1'b0;
    for (n = 0; n < max_wait && !seen; n++) begin
      @(negedge clk);
      seen = !out_valid;
    end
    if (!seen) begin
      err_count++;
      $display("timeout: out_valid stayed high for %0d cycles after the last input", max_wait);
    end
  endtask

  task automatic close_test(input string name, input int err_before);
    @(negedge clk);                             // last edge's checks have landed
    if (err_count == err_before) begin
      pass_count++;
      $display("test %s: pass", name);
    end else begin
      fail_count++;
      $display("test %s: fail, %0d errors", name, err_count - err_before);
    end
  endtask

  // ========================================
  // tests
  // ========================================
  task automatic run_reset();
    int err_before;
    err_before = err_count;
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    assert (out_valid == 1'b0 && act_flags == '0 && bar_type == '0)
      else begin
        err_count++;
        $display("error: after reset out_valid %h flags %h bar_type %h, expected 0",
                 out_valid, act_flags, bar_type);
      end
    close_test("reset", err_before);
  endtask

  // grp 0 runs every table entry
  task automatic run_directed(input int grp, input logic ill, input string name);
    int err_before;
    int i;
    err_before = err_count;
    for (i = 0; i < tbl_op.size(); i++) begin
      if (grp == 0 || tbl_grp[i] == grp) begin
        send_inst(tbl_op[i], tbl_amo[i], ill, 1'b1, tbl_flags[i], tbl_bar[i], 1'b1, i);
        send_inst(tbl_op[i], 1'b0, 1'b0, 1'b0, '0, '0, 1'b1, -1);
        wait_out_valid(i);
      end
    end
    close_test(name, err_before);
  endtask

  task automatic run_random(input int count);
    int err_before;
    int k;
    err_before = err_count;
    for (k = 0; k < count; k++) begin
      rnd = $urandom();
      send_inst($urandom(), rnd[4], rnd[3:2] == 2'b00, rnd[1:0] != 2'b00, '0, '0, 1'b0, -2);
    end
    send_inst('0, 1'b0, 1'b0, 1'b0, '0, '0, 1'b1, -1);
    wait_idle();
    close_test("random pipelining", err_before);
  endtask

  initial begin
    clk        = 1'b0;
    arst_n     <= 1'b0;
    in_valid   <= 1'b0;
    illegal    <= 1'b0;
    amo_staddr <= 1'b0;
    opcode     <= '0;
    pend_flags <= '0;
    pend_bar   <= '0;
    pend_chk   <= 1'b1;
    pend_idx   <= -1;
    err_count  = 0;
    pass_count = 0;
    fail_count = 0;
    rnd        = $urandom(32'hd5fe);
    build_table();
    run_reset();
    run_directed(2, 1'b0, "memory class");
    run_directed(3, 1'b0, "branch unit");
    run_directed(4, 1'b0, "vector and fp class");
    run_directed(0, 1'b1, "illegal masking");
    run_random(300);
    $display("tests passed %0d, failed %0d, check errors %0d", pass_count, fail_count,
             err_count);
    if (err_count == 0 && fail_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- hdl/ir_decd_top.sv
// rename-stage decode, result one cycle after in_valid; no ready, an inst may enter every cycle
`timescale 1ns/10ps

module ir_decd_top (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   in_valid,
  input  logic                   illegal,
  input  logic                   amo_staddr,
  input  ir_decd_pkg::opcode_t   opcode,
  output logic                   out_valid,
  output logic                   load,
  output logic                   store,
  output logic                   sync,
  output logic                   bar,
  output logic                   rts,
  output logic                   pcall,
  output logic                   pcfifo,
  output logic                   csr,
  output logic                   ecall,
  output logic                   vec,
  output logic                   fp,
  output logic                   vdiv,
  output logic                   vmul,
  output logic                   vsetvli,
  output logic                   vsetvl,
  output ir_decd_pkg::bar_type_t bar_type
);

  // unqualified decoder outputs
  logic                   raw_load;
  logic                   raw_store;
  logic                   raw_sync;
  logic                   raw_bar;
  logic                   raw_rts;
  logic                   raw_pcall;
  logic                   raw_pcfifo;
  logic                   raw_csr;
  logic                   raw_ecall;
  logic                   raw_vec;
  logic                   raw_fp;
  logic                   raw_vdiv;
  logic                   raw_vmul;
  logic                   raw_vsetvli;
  logic                   raw_vsetvl;
  ir_decd_pkg::bar_type_t raw_bar_type;

  // ========================================
  // decoders
  // ========================================
  ir_decd_int u_int (
    .opcode     (opcode),
    .amo_staddr (amo_staddr),
    .load       (raw_load),
    .store      (raw_store),
    .sync       (raw_sync),
    .bar        (raw_bar),
    .rts        (raw_rts),
    .pcall      (raw_pcall),
    .pcfifo     (raw_pcfifo),
    .csr        (raw_csr),
    .ecall      (raw_ecall),
    .bar_type   (raw_bar_type)
  );

  ir_decd_vfpu u_vfpu (
    .opcode  (opcode),
    .vec     (raw_vec),
    .fp      (raw_fp),
    .vdiv    (raw_vdiv),
    .vmul    (raw_vmul),
    .vsetvli (raw_vsetvli),
    .vsetvl  (raw_vsetvl)
  );

  // ========================================
  // qualify and register
  // ========================================
  ir_decd_issue_reg u_issue_reg (
    .clk          (clk),
    .arst_n       (arst_n),
    .in_valid     (in_valid),
    .illegal      (illegal),
    .raw_load     (raw_load),
    .raw_store    (raw_store),
    .raw_sync     (raw_sync),
    .raw_bar      (raw_bar),
    .raw_rts      (raw_rts),
    .raw_pcall    (raw_pcall),
    .raw_pcfifo   (raw_pcfifo),
    .raw_csr      (raw_csr),
    .raw_ecall    (raw_ecall),
    .raw_vec      (raw_vec),
    .raw_fp       (raw_fp),
    .raw_vdiv     (raw_vdiv),
    .raw_vmul     (raw_vmul),
    .raw_vsetvli  (raw_vsetvli),
    .raw_vsetvl   (raw_vsetvl),
    .raw_bar_type (raw_bar_type),
    .out_valid    (out_valid),
    .load         (load),
    .store        (store),
    .sync         (sync),
    .bar          (bar),
    .rts          (rts),
    .pcall        (pcall),
    .pcfifo       (pcfifo),
    .csr          (csr),
    .ecall        (ecall),
    .vec          (vec),
    .fp           (fp),
    .vdiv         (vdiv),
    .vmul         (vmul),
    .vsetvli      (vsetvli),
    .vsetvl       (vsetvl),
    .bar_type     (bar_type)
  );

endmodule

//--- hdl/ir_decd_issue_reg.sv
// one-cycle stage, no back-pressure; flags of an idle or illegal slot are forced to zero
`timescale 1ns/10ps
`include "ir_decd_config.svh"

module ir_decd_issue_reg (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   in_valid,
  input  logic                   illegal,
  input  logic                   raw_load,
  input  logic                   raw_store,
  input  logic                   raw_sync,
  input  logic                   raw_bar,
  input  logic                   raw_rts,
  input  logic                   raw_pcall,
  input  logic                   raw_pcfifo,
  input  logic                   raw_csr,
  input  logic                   raw_ecall,
  input  logic                   raw_vec,
  input  logic                   raw_fp,
  input  logic                   raw_vdiv,
  input  logic                   raw_vmul,
  input  logic                   raw_vsetvli,
  input  logic                   raw_vsetvl,
  input  ir_decd_pkg::bar_type_t raw_bar_type,
  output logic                   out_valid,
  output logic                   load,
  output logic                   store,
  output logic                   sync,
  output logic                   bar,
  output logic                   rts,
  output logic                   pcall,
  output logic                   pcfifo,
  output logic                   csr,
  output logic                   ecall,
  output logic                   vec,
  output logic                   fp,
  output logic                   vdiv,
  output logic                   vmul,
  output logic                   vsetvli,
  output logic                   vsetvl,
  output ir_decd_pkg::bar_type_t bar_type
);

  logic        keep;                        // slot carries a legal inst
  logic [14:0] flag_q;

  // illegal insts keep their opcode down the pipe, so mask here
  assign keep = in_valid && !illegal;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
      flag_q    <= '0;
      bar_type  <= '0;
    end else begin
      out_valid <= in_valid;                // illegal still counts as valid
      flag_q    <= {15{keep}} & {raw_load, raw_store, raw_sync, raw_bar, raw_rts,
                                 raw_pcall, raw_pcfifo, raw_csr, raw_ecall, raw_vec,
                                 raw_fp, raw_vdiv, raw_vmul, raw_vsetvli, raw_vsetvl};
      bar_type  <= {`IR_BAR_TYPE_W{keep}} & raw_bar_type;
    end
  end

  assign {load, store, sync, bar, rts, pcall, pcfifo, csr, ecall,
          vec, fp, vdiv, vmul, vsetvli, vsetvl} = flag_q;

endmodule

//--- hdl/ir_decd_vfpu.sv
// combinational only; vector encodings follow the core's vector unit, fp flags are class level
`timescale 1ns/10ps
`include "ir_decd_config.svh"

module ir_decd_vfpu (
  input  ir_decd_pkg::opcode_t opcode,
  output logic                 vec,
  output logic                 fp,
  output logic                 vdiv,
  output logic                 vmul,
  output logic                 vsetvli,
  output logic                 vsetvl
);

  logic [6:0] major;
  logic [2:0] funct3;
  logic [5:0] funct6;
  logic       is_v;
  logic       opivv;
  logic       opfvv;
  logic       opmvv;
  logic       opivx;
  logic       opfvf;
  logic       opmvx;
  logic       opcfg;
  logic       fdiv_sca;
  logic       vdiv_vec;
  logic       vmul_norm;
  logic       vmac_norm;
  logic       vmul_wide;
  logic       vmac_wide;

  assign major  = opcode[6:0];
  assign funct3 = opcode[14:12];
  assign funct6 = opcode[31:26];
  assign is_v   = (major == `IR_OP_OP_V);

  // ========================================
  // vector funct3 category
  // ========================================
  assign opivv = (funct3 == 3'b000);
  assign opfvv = (funct3 == 3'b001);
  assign opmvv = (funct3 == 3'b010);
  assign opivx = (funct3 == 3'b100);
  assign opfvf = (funct3 == 3'b101);
  assign opmvx = (funct3 == 3'b110);
  assign opcfg = (funct3 == 3'b111);        // vsetvl family

  assign vec = is_v;
  assign fp  = (major == `IR_OP_OP_FP)
            || ({opcode[6:4], opcode[1:0]} == 5'b100_11);  // fmadd..fnmadd

  // ========================================
  // divide / sqrt
  // ========================================
  assign fdiv_sca = (major == `IR_OP_OP_FP)
                 && ((opcode[31:27] == 5'b00011)       // fdiv.fmt
                  || (opcode[31:27] == 5'b01011));     // fsqrt.fmt

  assign vdiv_vec = is_v
                 && ((opcode[31:28] == 4'b1000) && (opmvv || opmvx)   // vdiv(u) vrem(u)
                  || (funct6 == 6'b100000) && (opfvv || opfvf)        // vfdiv
                  || (funct6 == 6'b100001) && opfvf                   // vfrdiv
                  || (funct6 == 6'b100011) && opfvv
                     && (opcode[19:15] == 5'd0));                     // vfsqrt

  assign vdiv = fdiv_sca || vdiv_vec;

  // ========================================
  // multiply / multiply-accumulate
  // ========================================
  assign vmul_norm = is_v
                  && ((funct6 == 6'b100111) && (opivv || opivx)       // vsmul
                   || (opcode[31:28] == 4'b1001) && (opmvv || opmvx)); // vmul vmulh*

  assign vmac_norm = is_v && (opmvv || opmvx)
                  && ((funct6 == 6'b101001)            // vmadd
                   || (funct6 == 6'b101011)            // vnmsub
                   || (funct6 == 6'b101101)            // vmacc
                   || (funct6 == 6'b101111));          // vnmsac

  assign vmul_wide = is_v && (opmvv || opmvx)
                  && ((funct6 == 6'b111000) || (opcode[31:27] == 5'b11101));

  // widening macc, integer and saturating forms
  assign vmac_wide = is_v && (opcode[31:28] == 4'b1111)
                  && (opivv || opivx || opmvv || opmvx);

  assign vmul = vmul_norm || vmac_norm || vmul_wide || vmac_wide;

  // ========================================
  // vector configuration
  // ========================================
  assign vsetvli = is_v && opcfg && !opcode[31];
  assign vsetvl  = is_v && opcfg && (opcode[31:25] == 7'b1000000);

endmodule

//--- hdl/ir_decd_int.sv
// combinational only; illegal insts are not filtered here and custom extensions are not decoded
`timescale 1ns/10ps
`include "ir_decd_config.svh"

module ir_decd_int (
  input  ir_decd_pkg::opcode_t   opcode,
  input  logic                   amo_staddr,    // amo issues as store address half
  output logic                   load,
  output logic                   store,
  output logic                   sync,
  output logic                   bar,
  output logic                   rts,
  output logic                   pcall,
  output logic                   pcfifo,
  output logic                   csr,
  output logic                   ecall,
  output ir_decd_pkg::bar_type_t bar_type
);

  logic [6:0]            major;
  logic [2:0]            funct3;
  logic [4:0]            funct5;
  ir_decd_pkg::reg_idx_t rd;
  ir_decd_pkg::reg_idx_t rs1;
  ir_decd_pkg::reg_idx_t rs2;
  logic [4:0]            c_op;
  logic                  c_rs2_zero;
  logic                  rd_link;
  logic                  rs1_link;
  logic                  ld_std;
  logic                  ld_comp;
  logic                  st_std;
  logic                  st_comp;
  logic                  amo_f5;
  logic                  amo;
  logic                  lr;
  logic                  sc;
  logic                  fence;
  logic                  fence_i;
  logic                  tlb_fence;
  logic                  bar_rw_sel;
  logic                  c_jr;
  logic                  c_jalr;
  logic                  c_jmp;
  logic                  jal;
  logic                  jalr;
  logic                  branch;

  // ========================================
  // field extraction
  // ========================================
  assign major      = opcode[6:0];
  assign funct3     = opcode[14:12];
  assign funct5     = opcode[31:27];
  assign rd         = opcode[11:7];         // also rs1 of c.jr / c.jalr
  assign rs1        = opcode[19:15];
  assign rs2        = opcode[24:20];
  assign c_op       = {opcode[15:13], opcode[1:0]};  // funct3 + quadrant
  assign c_rs2_zero = (opcode[6:2] == 5'd0);

  assign rd_link  = (rd == `IR_LINK_RA) || (rd == `IR_LINK_T0);
  assign rs1_link = (rs1 == `IR_LINK_RA) || (rs1 == `IR_LINK_T0);

  // ========================================
  // load and store
  // ========================================
  assign ld_std = (major == `IR_OP_LOAD) && (funct3 != 3'b111)
               || (major == `IR_OP_LOAD_FP);          // flh/flw/fld and vector loads

  assign ld_comp = (c_op == 5'b001_00)                 // c.fld
                || (c_op == 5'b010_00)                 // c.lw
                || (c_op == 5'b011_00)                 // c.ld
                || (c_op == 5'b001_10)                 // c.fldsp
                || ((c_op == 5'b010_10) || (c_op == 5'b011_10))
                   && (rd != 5'd0);                    // c.lwsp/c.ldsp, rd=0 reserved

  assign st_std = (major == `IR_OP_STORE) && !funct3[2]  // sb..sd
               || (major == `IR_OP_STORE_FP);

  assign st_comp = (c_op == 5'b101_00)                 // c.fsd
                || (c_op == 5'b110_00)                 // c.sw
                || (c_op == 5'b111_00)                 // c.sd
                || (c_op == 5'b101_10)                 // c.fsdsp
                || (c_op == 5'b110_10)                 // c.swsp
                || (c_op == 5'b111_10);                // c.sdsp

  // scalar amo function codes, .w and .d share them
  always_comb begin
    case (funct5)
      5'b00000, 5'b00001, 5'b00100, 5'b01100, 5'b01000,
      5'b10000, 5'b10100, 5'b11000, 5'b11100: amo_f5 = 1'b1;
      default: amo_f5 = 1'b0;
    endcase
  end

  assign amo = (major == `IR_OP_AMO) && (funct3[2:1] == 2'b01) && amo_f5;
  assign lr  = (major == `IR_OP_AMO) && (funct3[2:1] == 2'b01)
            && (funct5 == 5'b00010) && (rs2 == 5'd0);
  assign sc  = (major == `IR_OP_AMO) && (funct3[2:1] == 2'b01) && (funct5 == 5'b00011);

  // ========================================
  // fences
  // ========================================
  assign fence   = (major == `IR_OP_MISC_MEM) && (funct3 == 3'b000);
  assign fence_i = (major == `IR_OP_MISC_MEM) && (funct3 == 3'b001);

  assign tlb_fence = (major == `IR_OP_SYSTEM) && (opcode[14:7] == 8'd0)
                  && ((opcode[31:25] == 7'b0001001)    // sfence.vma
                   || (opcode[31:25] == 7'b0010001)    // hfence.vvma
                   || (opcode[31:25] == 7'b0110001));  // hfence.gvma

  // fence.i and tlb fences go down the store pipe
  assign load  = ld_std || ld_comp || lr || amo && !amo_staddr;
  assign store = st_std || st_comp || sc || fence_i || tlb_fence
              || amo && amo_staddr;
  assign sync  = lr || sc || amo || fence || fence_i || tlb_fence;
  assign bar   = fence;

  // pred = [27:24] iorw, succ = [23:20] iorw
  // anything with i/o on either side is treated as a full barrier
  assign bar_rw_sel = (opcode[25] || opcode[24]) && !(opcode[27] || opcode[26])
                   && (opcode[21] || opcode[20]) && !(opcode[23] || opcode[22]);

  assign bar_type = !fence    ? '0 :                   // zero outside fences
                    bar_rw_sel ? `IR_BAR_RW_RW : `IR_BAR_FULL;

  // ========================================
  // branch unit
  // ========================================
  assign c_jr   = ({opcode[15:12], opcode[1:0]} == 6'b1000_10) && c_rs2_zero
               && (rd != 5'd0);
  assign c_jalr = ({opcode[15:12], opcode[1:0]} == 6'b1001_10) && c_rs2_zero
               && (rd != 5'd0);                        // always links x1
  assign c_jmp  = (c_op == 5'b101_01)                  // c.j
               || (c_op == 5'b110_01)                  // c.beqz
               || (c_op == 5'b111_01);                 // c.bnez
  assign jal    = (major == `IR_OP_JAL);
  assign jalr   = (major == `IR_OP_JALR) && (funct3 == 3'b000);
  assign branch = (major == `IR_OP_BRANCH) && (funct3[2:1] != 2'b01);

  // return stack pop, link hint rules of the base spec
  assign rts = c_jr && rd_link
            || c_jalr && (rd == `IR_LINK_T0)           // pop t0, push ra
            || jalr && rs1_link && (rs1 != rd);        // rs1 == rd is push only

  // return stack push
  assign pcall = c_jalr
              || jal && rd_link
              || jalr && rd_link;

  assign pcfifo = c_jmp || c_jr || c_jalr || jal || jalr || branch
               || (major == `IR_OP_AUIPC);

  // ========================================
  // system
  // ========================================
  assign csr   = (major == `IR_OP_SYSTEM) && (funct3 != 3'b000);
  assign ecall = (opcode == 32'h0000_0073);

endmodule

//--- hdl/ir_decd_pkg.sv
// width types for the rename-stage decoder; widths come from the config header only
`include "ir_decd_config.svh"

package ir_decd_pkg;

  // ========================================
  // instruction and register fields
  // ========================================
  typedef logic [`IR_OPCODE_W-1:0]   opcode_t;    // 16-bit insts sit in bits 15:0
  typedef logic [`IR_REG_IDX_W-1:0]  reg_idx_t;

  // ========================================
  // barrier ordering
  // ========================================
  // {pred_r|succ_r summary} style code, only two values are produced
  typedef logic [`IR_BAR_TYPE_W-1:0] bar_type_t;

endpackage

//--- hdl/ir_decd_config.svh
// isa-fixed widths and encodings; values must match the rv64 base, c, f/d and v specs
`ifndef IR_DECD_CONFIG_SVH
`define IR_DECD_CONFIG_SVH

`define IR_OPCODE_W    32           // one instruction word
`define IR_REG_IDX_W   5            // x0..x31
`define IR_BAR_TYPE_W  4

`define IR_BAR_FULL    4'b1111      // full fence, lsiq waits for everything
`define IR_BAR_RW_RW   4'b1010      // pred/succ limited to r/w

`define IR_LINK_RA     5'd1
`define IR_LINK_T0     5'd5         // alternate link register

`define IR_OP_LOAD     7'b0000011
`define IR_OP_LOAD_FP  7'b0000111   // also vector loads
`define IR_OP_STORE    7'b0100011
`define IR_OP_STORE_FP 7'b0100111   // also vector stores
`define IR_OP_AMO      7'b0101111
`define IR_OP_MISC_MEM 7'b0001111
`define IR_OP_SYSTEM   7'b1110011
`define IR_OP_BRANCH   7'b1100011
`define IR_OP_JAL      7'b1101111
`define IR_OP_JALR     7'b1100111
`define IR_OP_AUIPC    7'b0010111
`define IR_OP_OP_FP    7'b1010011
`define IR_OP_OP_V     7'b1010111

`endif
